//--- common/trap_pkg.sv
// Trap unit shared definitions
package trap_pkg;

    // Data word.
    typedef logic [31:0] xlen_t;
    // Halfword-aligned address, bits 31..1.
    typedef logic [31:1] pc_t;
    // Word-aligned trap vector, bits 31..2.
    typedef logic [31:2] tvec_t;
    // CSR address.
    typedef logic [11:0] csr_addr_t;
    // Trap or interrupt number.
    typedef logic [4:0]  cause_t;

    // Privilege modes, encoded as in mstatus.MPP.
    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_t;

    // CSR access request.
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        xlen_t     wdata;
    } csr_req_t;

    // CSR access response.
    typedef struct packed {
        logic  exists;
        logic  rdonly;
        xlen_t rdata;
    } csr_rsp_t;

    // Instruction leaving the pipeline.
    typedef struct packed {
        logic   valid;
        logic   trap;
        cause_t cause;
        pc_t    pc;
    } retire_t;

    // Exception event towards the CSR file.
    typedef struct packed {
        logic   irq;
        logic   trap;
        cause_t cause;
        pc_t    epc;
        priv_t  prev_priv;
    } exc_t;

    // Machine CSR addresses.
    localparam csr_addr_t CSR_MSTATUS    = 12'h300;
    localparam csr_addr_t CSR_MISA       = 12'h301;
    localparam csr_addr_t CSR_MEDELEG    = 12'h302;
    localparam csr_addr_t CSR_MIDELEG    = 12'h303;
    localparam csr_addr_t CSR_MIE        = 12'h304;
    localparam csr_addr_t CSR_MTVEC      = 12'h305;
    localparam csr_addr_t CSR_MSTATUSH   = 12'h310;
    localparam csr_addr_t CSR_MSCRATCH   = 12'h340;
    localparam csr_addr_t CSR_MEPC       = 12'h341;
    localparam csr_addr_t CSR_MCAUSE     = 12'h342;
    localparam csr_addr_t CSR_MTVAL      = 12'h343;
    localparam csr_addr_t CSR_MIP        = 12'h344;
    localparam csr_addr_t CSR_MVENDORID  = 12'hf11;
    localparam csr_addr_t CSR_MARCHID    = 12'hf12;
    localparam csr_addr_t CSR_MIMPID     = 12'hf13;
    localparam csr_addr_t CSR_MHARTID    = 12'hf14;
    localparam csr_addr_t CSR_MCONFIGPTR = 12'hf15;

    // Identification values.
    localparam xlen_t MARCHID_VAL = 32'd37;
    // Major version 2 in bits 15..8, divider latency 2 in bits 21..16.
    localparam xlen_t MIMPID_VAL  = 32'h0002_0200;
    localparam xlen_t MHARTID_VAL = 32'd0;
    // MXL 1 (32-bit), with A, C, I and M.
    localparam xlen_t MISA_VAL    = 32'h4000_1105;

    // Edges of MIE before interrupts are allowed.
    localparam int IRQ_EN_DEPTH = 2;
    // Lowest external interrupt line.
    localparam int IRQ_EXT_LO   = 16;
    // Machine timer interrupt line.
    localparam int IRQ_TIMER    = 7;

    // mstatus bit positions.
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LO   = 11;
    localparam int MSTATUS_MPRV_BIT = 17;

endpackage

//--- source/irq_arbiter.sv
// Interrupt latch and priority arbiter
`timescale 1ns/1ps

module irq_arbiter import trap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // External lines 31..16.
    input  logic [15:0] irq,
    // Machine timer line.
    input  logic        timer_irq,
    // Per-line enables from the mie CSR.
    input  xlen_t       mie,
    // Global enable mstatus.MIE.
    input  logic        status_mie,
    // Latched interrupt lines.
    output xlen_t       irq_pending,
    // Winning interrupt number, 0 when none.
    output cause_t      irq_cause,
    // Interrupts may be taken.
    output logic        irq_en
);

    // Pending lines that are also enabled.
    xlen_t                   irq_masked;
    // History of status_mie over the last edges.
    logic [IRQ_EN_DEPTH-1:0] mie_hist;

    // Latch the lines into their mip positions.
    always_ff @(posedge clk) begin
        if (rst) begin
            irq_pending <= '0;
        end else begin
            irq_pending                         <= '0;
            irq_pending[IRQ_EXT_LO +: 16]       <= irq;
            irq_pending[IRQ_TIMER]              <= timer_irq;
        end
    end

    assign irq_masked = irq_pending & mie;

    // Lowest set index wins.
    // Scan from the top so the last hit is the lowest.
    always_comb begin
        irq_cause = '0;
        for (int i = 31; i >= 0; i--) begin
            if (irq_masked[i]) begin
                irq_cause = cause_t'(i);
            end
        end
    end

    // Enable settles only after MIE was seen at every recent edge.
    always_ff @(posedge clk) begin
        if (rst) begin
            mie_hist <= '0;
        end else begin
            mie_hist <= {mie_hist[IRQ_EN_DEPTH-2:0], status_mie};
        end
    end

    // Drops in the same cycle as MIE.
    assign irq_en = (&mie_hist) && status_mie;

endmodule

//--- source/trap_dispatch.sv
// Trap dispatch and privilege tracking
`timescale 1ns/1ps

module trap_dispatch import trap_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    // Instruction leaving the pipeline.
    input  retire_t retire,
    // Return strobe.
    input  logic    mret,
    // Winning interrupt, 0 when none.
    input  cause_t  irq_cause,
    // Interrupts allowed.
    input  logic    irq_en,
    // Current trap vector.
    input  tvec_t   mtvec,
    // Current return address.
    input  pc_t     mepc,
    // Privilege to return to.
    input  priv_t   mpp,
    // Exception event to the CSR file.
    output exc_t    exc,
    // An exception is taken this cycle.
    output logic    take_trap,
    // Where the exception goes.
    output tvec_t   trap_vector,
    // Where mret goes.
    output pc_t     ret_target,
    // Current privilege mode.
    output priv_t   cur_priv
);

    // Interrupt has priority over a synchronous trap.
    always_comb begin
        exc           = '0;
        exc.epc       = retire.pc;
        exc.prev_priv = cur_priv;
        if (irq_cause != '0 && irq_en && retire.valid) begin
            // Interrupt.
            exc.irq   = 1'b1;
            exc.cause = irq_cause;
        end else if (retire.valid && retire.trap) begin
            // Synchronous trap.
            exc.trap  = 1'b1;
            exc.cause = retire.cause;
        end
    end

    assign take_trap   = exc.irq | exc.trap;
    assign trap_vector = mtvec;
    assign ret_target  = mepc;

    // Privilege mode.
    always_ff @(posedge clk) begin
        if (rst) begin
            cur_priv <= PRIV_M;
        end else if (take_trap) begin
            // Every exception enters M mode.
            cur_priv <= PRIV_M;
        end else if (mret) begin
            // Back to the saved mode.
            cur_priv <= mpp;
        end
    end

endmodule

//--- csr/csr_file.sv
// Machine CSR file
`timescale 1ns/1ps

module csr_file import trap_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    // CSR access.
    input  csr_req_t csr_req,
    output csr_rsp_t csr_rsp,
    // Exception event from dispatch.
    input  exc_t     exc,
    // Return strobe.
    input  logic     mret,
    // Latched interrupt lines.
    input  xlen_t    irq_pending,
    // Per-line interrupt enables.
    output xlen_t    mie,
    // Global interrupt enable.
    output logic     status_mie,
    // Trap vector.
    output tvec_t    mtvec,
    // Return address.
    output pc_t      mepc,
    // Previous privilege.
    output priv_t    mpp
);

    // mstatus fields.
    logic   status_mpie;
    logic   status_mprv;
    // Scratch register.
    xlen_t  mscratch;
    // mcause fields.
    logic   mcause_int;
    cause_t mcause_no;

    // Assembled read values.
    xlen_t  mstatus_val;
    xlen_t  mcause_val;
    xlen_t  mip_val;

    // Exception this cycle.
    logic   exc_take;

    assign exc_take = exc.irq | exc.trap;

    // S-mode and other fields read as zero.
    always_comb begin
        mstatus_val                           = '0;
        mstatus_val[MSTATUS_MIE_BIT]          = status_mie;
        mstatus_val[MSTATUS_MPIE_BIT]         = status_mpie;
        mstatus_val[MSTATUS_MPP_LO +: 2]      = mpp;
        mstatus_val[MSTATUS_MPRV_BIT]         = status_mprv;
    end

    assign mcause_val = {mcause_int, 26'b0, mcause_no};
    assign mip_val    = irq_pending & mie;

    // Read mux.
    always_comb begin
        csr_rsp.exists = 1'b1;
        csr_rsp.rdonly = 1'b0;
        csr_rsp.rdata  = '0;
        case (csr_req.addr)
            CSR_MSTATUS:    csr_rsp.rdata = mstatus_val;
            CSR_MISA:       csr_rsp.rdata = MISA_VAL;
            CSR_MEDELEG:    csr_rsp.rdata = '0;
            CSR_MIDELEG:    csr_rsp.rdata = '0;
            CSR_MIE:        csr_rsp.rdata = mie;
            CSR_MTVEC:      csr_rsp.rdata = {mtvec, 2'b00};
            CSR_MSTATUSH:   csr_rsp.rdata = '0;
            CSR_MIP:        csr_rsp.rdata = mip_val;
            CSR_MSCRATCH:   csr_rsp.rdata = mscratch;
            CSR_MEPC:       csr_rsp.rdata = {mepc, 1'b0};
            CSR_MCAUSE:     csr_rsp.rdata = mcause_val;
            CSR_MTVAL:      csr_rsp.rdata = '0;
            // Identification registers are read-only.
            CSR_MVENDORID: begin
                csr_rsp.rdonly = 1'b1;
            end
            CSR_MARCHID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = MARCHID_VAL;
            end
            CSR_MIMPID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = MIMPID_VAL;
            end
            CSR_MHARTID: begin
                csr_rsp.rdonly = 1'b1;
                csr_rsp.rdata  = MHARTID_VAL;
            end
            CSR_MCONFIGPTR: begin
                csr_rsp.rdonly = 1'b1;
            end
            default: begin
                csr_rsp.exists = 1'b0;
            end
        endcase
    end

    // Updates in order exception, return, write.
    always_ff @(posedge clk) begin
        if (rst) begin
            status_mie  <= 1'b0;
            status_mpie <= 1'b0;
            status_mprv <= 1'b0;
            mpp         <= PRIV_U;
            mie         <= '0;
            mtvec       <= '0;
            mscratch    <= '0;
            mepc        <= '0;
            mcause_int  <= 1'b0;
            mcause_no   <= '0;
        end else if (exc_take) begin
            // Save state and disable interrupts.
            status_mpie <= status_mie;
            status_mie  <= 1'b0;
            mpp         <= exc.prev_priv;
            mepc        <= exc.epc;
            mcause_int  <= exc.irq;
            mcause_no   <= exc.cause;
        end else if (mret) begin
            // Restore interrupt enable.
            status_mie  <= status_mpie;
            // MPRV stays only when returning to M mode.
            status_mprv <= status_mprv && (mpp == PRIV_M);
        end else if (csr_req.we) begin
            case (csr_req.addr)
                CSR_MSTATUS: begin
                    status_mie  <= csr_req.wdata[MSTATUS_MIE_BIT];
                    status_mpie <= csr_req.wdata[MSTATUS_MPIE_BIT];
                    status_mprv <= csr_req.wdata[MSTATUS_MPRV_BIT];
                    // Only M and U exist.
                    mpp <= (csr_req.wdata[MSTATUS_MPP_LO +: 2] != 2'b00) ? PRIV_M : PRIV_U;
                end
                CSR_MIE:      mie      <= csr_req.wdata;
                CSR_MTVEC:    mtvec    <= csr_req.wdata[31:2];
                CSR_MSCRATCH: mscratch <= csr_req.wdata;
                CSR_MEPC:     mepc     <= csr_req.wdata[31:1];
                CSR_MCAUSE: begin
                    mcause_int <= csr_req.wdata[31];
                    mcause_no  <= csr_req.wdata[4:0];
                end
                default: ;
            endcase
        end
    end

endmodule

//--- source/trap_unit.sv
// Machine-mode trap and CSR unit
`timescale 1ns/1ps

module trap_unit import trap_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // CSR access.
    input  csr_req_t    csr_req,
    output csr_rsp_t    csr_rsp,
    // Instruction leaving the pipeline.
    input  retire_t     retire,
    // Return strobe.
    input  logic        mret,
    // External lines 31..16.
    input  logic [15:0] irq,
    // Machine timer line.
    input  logic        timer_irq,
    // Exception taken this cycle.
    output logic        take_trap,
    // Exception target.
    output tvec_t       trap_vector,
    // Return target.
    output pc_t         ret_target,
    // Current privilege mode.
    output priv_t       cur_priv
);

    // Arbiter outputs.
    xlen_t  irq_pending;
    cause_t irq_cause;
    logic   irq_en;

    // CSR file outputs.
    xlen_t  mie;
    logic   status_mie;
    tvec_t  mtvec;
    pc_t    mepc;
    priv_t  mpp;

    // Dispatch event.
    exc_t   exc;

    irq_arbiter i_irq_arbiter (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .timer_irq   (timer_irq),
        .mie         (mie),
        .status_mie  (status_mie),
        .irq_pending (irq_pending),
        .irq_cause   (irq_cause),
        .irq_en      (irq_en)
    );

    trap_dispatch i_trap_dispatch (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire),
        .mret        (mret),
        .irq_cause   (irq_cause),
        .irq_en      (irq_en),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mpp         (mpp),
        .exc         (exc),
        .take_trap   (take_trap),
        .trap_vector (trap_vector),
        .ret_target  (ret_target),
        .cur_priv    (cur_priv)
    );

    csr_file i_csr_file (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .csr_rsp     (csr_rsp),
        .exc         (exc),
        .mret        (mret),
        .irq_pending (irq_pending),
        .mie         (mie),
        .status_mie  (status_mie),
        .mtvec       (mtvec),
        .mepc        (mepc),
        .mpp         (mpp)
    );

endmodule

//--- testbench/trap_unit_sva.sv
// Trap dispatch assertions
`timescale 1ns/1ps

module trap_unit_sva import trap_pkg::*; (
    input logic    clk,
    input logic    rst,
    input retire_t retire,
    input logic    take_trap,
    input priv_t   cur_priv
);

    // An exception always has a retiring instruction behind it.
    a_trap_needs_retire: assert property (@(posedge clk) disable iff (rst)
        take_trap |-> retire.valid)
    else $error("take_trap raised without a valid retiring instruction");

    // Every exception enters M mode at the edge that ends it.
    a_trap_enters_m: assert property (@(posedge clk) disable iff (rst)
        take_trap |=> cur_priv == PRIV_M)
    else $error("cur_priv is not M after an exception");

endmodule

// Watch every trap unit instance.
bind trap_unit trap_unit_sva i_trap_unit_sva (
    .clk       (clk),
    .rst       (rst),
    .retire    (retire),
    .take_trap (take_trap),
    .cur_priv  (cur_priv)
);

//--- testbench/trap_unit_tb.sv
// Trap unit testbench
`timescale 1ns/1ps

module trap_unit_tb import trap_pkg::*;;

    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] SEED         = 32'hf239_b199;
    // Lines 7 and 20 enabled in mie.
    localparam xlen_t       MIE_MASK     = 32'h0010_0080;
    localparam retire_t     NO_RET       = '0;

    // One stimulus row with its expected outputs.
    typedef struct packed {
        csr_req_t    req;
        retire_t     ret;
        logic        mret;
        logic [15:0] irq;
        logic        timer;
        logic        exp_take;
        csr_rsp_t    exp_rsp;
        priv_t       exp_priv;
        tvec_t       exp_vec;
        pc_t         exp_ret;
    } row_t;

    logic        clk;
    logic        rst;
    csr_req_t    csr_req;
    csr_rsp_t    csr_rsp;
    retire_t     retire;
    logic        mret;
    logic [15:0] irq;
    logic        timer_irq;
    logic        take_trap;
    tvec_t       trap_vector;
    pc_t         ret_target;
    priv_t       cur_priv;

    row_t        rows[$];
    bit          table_ready;
    int          cycle_count;
    int          cycle_limit;
    // Levels and expectations that carry over between rows.
    logic [15:0] row_irq;
    logic        row_timer;
    logic        row_mret;
    priv_t       row_priv;
    tvec_t       row_vec;
    pc_t         row_ret;
    xlen_t       scratch;
    pc_t         pc1, pc2, pc3, pc4;

    trap_unit i_trap_unit (
        .clk         (clk),
        .rst         (rst),
        .csr_req     (csr_req),
        .csr_rsp     (csr_rsp),
        .retire      (retire),
        .mret        (mret),
        .irq         (irq),
        .timer_irq   (timer_irq),
        .take_trap   (take_trap),
        .trap_vector (trap_vector),
        .ret_target  (ret_target),
        .cur_priv    (cur_priv)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_word(string name, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_priv(string name, priv_t got, priv_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_vector(string name, tvec_t got, tvec_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(string name, pc_t got, pc_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Flags first, then the read data.
    task automatic check_rsp(string name, csr_rsp_t got, csr_rsp_t exp);
        if (got.exists !== exp.exists || got.rdonly !== exp.rdonly) begin
            $display("** Error at %0t ns: %s exists/rdonly = %b/%b, expected %b/%b",
                     $time, name, got.exists, got.rdonly, exp.exists, exp.rdonly);
            abort_run();
        end else begin
            check_word({name, ".rdata"}, got.rdata, exp.rdata);
        end
    endtask

    // MXL 1 with the A, C, I and M letters.
    function automatic xlen_t misa_expect();
        xlen_t v;
        v        = '0;
        v[31:30] = 2'b01;
        v[0]     = 1'b1;
        v[2]     = 1'b1;
        v[8]     = 1'b1;
        v[12]    = 1'b1;
        return v;
    endfunction

    function automatic xlen_t mstatus_word(logic ie, logic pie, priv_t pp);
        xlen_t v;
        v                        = '0;
        v[MSTATUS_MIE_BIT]       = ie;
        v[MSTATUS_MPIE_BIT]      = pie;
        v[MSTATUS_MPP_LO +: 2]   = pp;
        return v;
    endfunction

    function automatic csr_req_t read_req(csr_addr_t a);
        return {1'b0, a, 32'h0};
    endfunction

    function automatic csr_req_t write_req(csr_addr_t a, xlen_t d);
        return {1'b1, a, d};
    endfunction

    function automatic retire_t ok_retire(pc_t pc);
        return {1'b1, 1'b0, 5'd0, pc};
    endfunction

    function automatic retire_t trap_retire(cause_t c, pc_t pc);
        return {1'b1, 1'b1, c, pc};
    endfunction

    function automatic csr_rsp_t rw_data(xlen_t d);
        return {1'b1, 1'b0, d};
    endfunction

    function automatic csr_rsp_t ro_data(xlen_t d);
        return {1'b1, 1'b1, d};
    endfunction

    task automatic add_row(csr_req_t req, retire_t ret, logic take, csr_rsp_t rsp);
        rows.push_back({req, ret, row_mret, row_irq, row_timer, take, rsp, row_priv, row_vec,
                        row_ret});
    endtask

    task automatic build_table();
        row_irq   = '0;
        row_timer = 1'b0;
        row_mret  = 1'b0;
        row_priv  = PRIV_M;
        row_vec   = '0;
        row_ret   = '0;
        // Reset state.
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MTVEC), NO_RET, 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MCAUSE), NO_RET, 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MARCHID), NO_RET, 1'b0, ro_data(32'd37));
        add_row(read_req(CSR_MISA), NO_RET, 1'b0, rw_data(misa_expect()));
        add_row(read_req(12'h7c0), NO_RET, 1'b0, '0);
        // Plain reads and writes; a write shows only from the next row.
        add_row(write_req(CSR_MSCRATCH, scratch), NO_RET, 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MSCRATCH), NO_RET, 1'b0, rw_data(scratch));
        add_row(write_req(CSR_MTVEC, 32'h0000_1003), NO_RET, 1'b0, rw_data(32'h0));
        row_vec = 30'h400;
        add_row(read_req(CSR_MTVEC), NO_RET, 1'b0, rw_data(32'h0000_1000));
        add_row(write_req(CSR_MEPC, 32'h0000_2223), NO_RET, 1'b0, rw_data(32'h0));
        row_ret = 31'h1111;
        add_row(read_req(CSR_MEPC), NO_RET, 1'b0, rw_data(32'h0000_2222));
        add_row(write_req(CSR_MHARTID, 32'hdead_beef), NO_RET, 1'b0, ro_data(32'h0));
        add_row(read_req(CSR_MHARTID), NO_RET, 1'b0, ro_data(32'h0));
        // Line 16 pends but stays masked in mip.
        row_irq   = 16'h0011;
        row_timer = 1'b1;
        add_row(write_req(CSR_MIE, MIE_MASK), NO_RET, 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MIP), NO_RET, 1'b0, rw_data(MIE_MASK));
        row_irq   = '0;
        row_timer = 1'b0;
        // Synchronous trap from M with MIE on.
        add_row(write_req(CSR_MSTATUS, mstatus_word(1'b1, 1'b0, PRIV_U)), NO_RET, 1'b0,
                rw_data(32'h0));
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b1, 1'b0, PRIV_U)));
        add_row(read_req(CSR_MCAUSE), trap_retire(5'd2, pc1), 1'b1, rw_data(32'h0));
        row_ret = pc1;
        add_row(read_req(CSR_MCAUSE), NO_RET, 1'b0, rw_data(32'd2));
        add_row(read_req(CSR_MEPC), NO_RET, 1'b0, rw_data({pc1, 1'b0}));
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b0, 1'b1, PRIV_M)));
        // Return into U mode, then trap back to M.
        add_row(write_req(CSR_MSTATUS, mstatus_word(1'b0, 1'b1, PRIV_U)), NO_RET, 1'b0,
                rw_data(mstatus_word(1'b0, 1'b1, PRIV_M)));
        row_mret = 1'b1;
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b0, 1'b1, PRIV_U)));
        row_mret = 1'b0;
        row_priv = PRIV_U;
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b1, 1'b1, PRIV_U)));
        add_row(read_req(CSR_MCAUSE), trap_retire(5'd3, pc2), 1'b1, rw_data(32'd2));
        row_priv = PRIV_M;
        row_ret  = pc2;
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b0, 1'b1, PRIV_U)));
        // Masked line 16 with MIE settled.
        row_irq = 16'h0001;
        add_row(write_req(CSR_MSTATUS, mstatus_word(1'b1, 1'b0, PRIV_U)), NO_RET, 1'b0,
                rw_data(mstatus_word(1'b0, 1'b1, PRIV_U)));
        add_row(read_req(CSR_MIP), ok_retire(pc2), 1'b0, rw_data(32'h0));
        add_row(read_req(CSR_MSTATUS), ok_retire(pc2), 1'b0,
                rw_data(mstatus_word(1'b1, 1'b0, PRIV_U)));
        add_row(read_req(CSR_MIP), ok_retire(pc2), 1'b0, rw_data(32'h0));
        // MIE off, then on; lines 7 and 20 wait for two edges of MIE.
        row_irq = '0;
        add_row(write_req(CSR_MSTATUS, 32'h0), NO_RET, 1'b0,
                rw_data(mstatus_word(1'b1, 1'b0, PRIV_U)));
        row_irq   = 16'h0010;
        row_timer = 1'b1;
        add_row(write_req(CSR_MSTATUS, mstatus_word(1'b1, 1'b0, PRIV_U)), ok_retire(pc3), 1'b0,
                rw_data(32'h0));
        add_row(read_req(CSR_MCAUSE), ok_retire(pc3), 1'b0, rw_data(32'd3));
        add_row(read_req(CSR_MCAUSE), ok_retire(pc3), 1'b0, rw_data(32'd3));
        add_row(read_req(CSR_MCAUSE), ok_retire(pc3), 1'b1, rw_data(32'd3));
        row_ret = pc3;
        add_row(read_req(CSR_MCAUSE), ok_retire(pc3), 1'b0, rw_data(32'h8000_0007));
        // Line 20 against a synchronous trap.
        row_timer = 1'b0;
        add_row(write_req(CSR_MSTATUS, mstatus_word(1'b1, 1'b0, PRIV_U)), NO_RET, 1'b0,
                rw_data(mstatus_word(1'b0, 1'b1, PRIV_M)));
        add_row(read_req(CSR_MSTATUS), NO_RET, 1'b0, rw_data(mstatus_word(1'b1, 1'b0, PRIV_U)));
        add_row(read_req(CSR_MIP), NO_RET, 1'b0, rw_data(32'h0010_0000));
        add_row(read_req(CSR_MEPC), trap_retire(5'd2, pc4), 1'b1, rw_data({pc3, 1'b0}));
        row_irq = '0;
        row_ret = pc4;
        add_row(read_req(CSR_MCAUSE), NO_RET, 1'b0, rw_data(32'h8000_0014));
        add_row(read_req(CSR_MEPC), NO_RET, 1'b0, rw_data({pc4, 1'b0}));
    endtask

    task automatic drive_row(row_t r);
        csr_req   = r.req;
        retire    = r.ret;
        mret      = r.mret;
        irq       = r.irq;
        timer_irq = r.timer;
    endtask

    // Run limit from the table length.
    initial begin
        cycle_count = 0;
        wait (table_ready);
        cycle_limit = rows.size() + RESET_CYCLES + 20;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the table did not finish within %0d cycles", cycle_limit);
        abort_run();
    end

    initial begin
        void'($urandom(SEED));
        rst       = 1'b1;
        csr_req   = '0;
        retire    = '0;
        mret      = 1'b0;
        irq       = '0;
        timer_irq = 1'b0;
        scratch   = $urandom();
        pc1       = pc_t'($urandom());
        pc2       = pc_t'($urandom());
        pc3       = pc_t'($urandom());
        pc4       = pc_t'($urandom());
        build_table();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #5;
        rst = 1'b0;
        foreach (rows[i]) begin
            drive_row(rows[i]);
            // Sample just before the next edge.
            #90;
            check_bit($sformatf("row %0d take_trap", i), take_trap, rows[i].exp_take);
            check_rsp($sformatf("row %0d csr_rsp", i), csr_rsp, rows[i].exp_rsp);
            check_priv($sformatf("row %0d cur_priv", i), cur_priv, rows[i].exp_priv);
            check_vector($sformatf("row %0d trap_vector", i), trap_vector, rows[i].exp_vec);
            check_pc($sformatf("row %0d ret_target", i), ret_target, rows[i].exp_ret);
            @(posedge clk);
            #5;
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- trap_unit.f
common/trap_pkg.sv
source/irq_arbiter.sv
source/trap_dispatch.sv
csr/csr_file.sv
source/trap_unit.sv
testbench/trap_unit_sva.sv
testbench/trap_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the trap unit simulation with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module trap_unit_tb -f trap_unit.f --Mdir obj_dir -o trap_unit_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/trap_unit_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

exit 0
